/* tb.f */
design/cpu_pkg.sv
design/register_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu_top.sv
sim/cpu_assertions.sv
sim/cpu_tb.sv

/* sim/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb import cpu_pkg::*; ();

  localparam int code_words = 16;
  localparam int data_words = 16;
  localparam int timeout_cycles = 2000;

  logic                       clk;
  logic                       nreset;
  logic                       imem_we;
  logic [3:0]                 imem_addr;
  logic [word_width-1:0]      imem_wdata;
  logic                       retire_valid;
  logic [reg_index_width-1:0] retire_reg;
  logic [word_width-1:0]      retire_data;
  logic                       store_valid;
  logic [3:0]                 store_addr;
  logic [word_width-1:0]      store_data;

  // program image and the instruction-level model state
  logic [31:0] prog [0:code_words-1];
  logic [31:0] model_regs [0:14];
  logic [31:0] model_mem [0:data_words-1];
  logic [31:0] lfsr_state;

  // expected register writes and stores, in program order
  logic [3:0]  exp_reg[$];
  logic [31:0] exp_val[$];
  logic [3:0]  exp_saddr[$];
  logic [31:0] exp_sdata[$];

  int  retire_errors;
  int  store_errors;
  int  other_errors;
  logic timed_out;

  cpu_top #(.CODE_WORDS(code_words), .DATA_WORDS(data_words)) UUT (
    .clk          (clk),
    .nreset       (nreset),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_wdata   (imem_wdata),
    .retire_valid (retire_valid),
    .retire_reg   (retire_reg),
    .retire_data  (retire_data),
    .store_valid  (store_valid),
    .store_addr   (store_addr),
    .store_data   (store_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random source

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one step per bit, msb first
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // program generator

  task automatic gen_program();
    logic [3:0]  opcodes [0:8];
    logic [3:0]  op;
    logic [3:0]  cond;
    logic [2:0]  rn;
    logic [2:0]  rd;
    logic [2:0]  prev_rd;
    logic [2:0]  kind;
    logic        imm;
    logic        s;
    logic [11:0] op2;
    logic [11:0] imm12;
    int          target;
    opcodes = '{opcode_and, opcode_eor, opcode_sub, opcode_add, opcode_cmp,
                opcode_orr, opcode_mov, opcode_bic, opcode_mvn};
    prev_rd = '0;
    for (int i = 0; i < 15; i++) begin
      rd = 3'(take_bits(3));
      if (i < 4) begin
        // seed a few registers with mov immediates
        op2 = {4'd0, 8'(take_bits(8))};
        prog[i] = {cond_al, type_data_proc, 1'b1, opcode_mov, 1'b0, 4'd0, {1'b0, rd}, op2};
        prev_rd = rd;
        continue;
      end
      kind = 3'(take_bits(3));
      // half the sources reuse the last result, to hit forwarding and load-use
      if (take_bits(1) != 0) begin
        rn = prev_rd;
      end else begin
        rn = 3'(take_bits(3));
      end
      if (kind < 3'd4) begin
        op  = opcodes[take_bits(4) % 9];
        imm = take_bits(1);
        s   = take_bits(1);
        if (imm) begin
          op2 = {4'd0, 8'(take_bits(8))};
        end else begin
          op2 = {9'd0, 3'(take_bits(3))};
        end
        prog[i] = {cond_al, type_data_proc, imm, op, s, {1'b0, rn}, {1'b0, rd}, op2};
        if (op != opcode_cmp) begin
          prev_rd = rd;
        end
      end else if (kind < 3'd6) begin
        // immediate offset, pre-indexed, up, word, no writeback
        imm12 = {6'd0, 4'(take_bits(4)), 2'b00};
        prog[i] = {cond_al, type_ldr_str, 5'b01100, kind == 3'd4, {1'b0, rn}, {1'b0, rd},
                   imm12};
        if (kind == 3'd4) begin
          prev_rd = rd;
        end
      end else begin
        cond = 4'(take_bits(4));
        if (cond == 4'hf) begin
          cond = cond_al;
        end
        // forward only, somewhere in i+1 .. 15
        target = i + 1 + int'(take_bits(4)) % (15 - i);
        prog[i] = {cond, type_branch, 2'b10, 24'(target - i - 2)};
      end
    end
    // park on a branch to itself
    prog[15] = {cond_al, type_branch, 2'b10, 24'hfffffe};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // instruction-level model

  function automatic logic cond_holds(input logic [3:0] cond, input logic n, z, c, v);
    case (cond)
      cond_eq: return z;
      cond_ne: return !z;
      cond_cs: return c;
      cond_cc: return !c;
      cond_mi: return n;
      cond_pl: return !n;
      cond_vs: return v;
      cond_vc: return !v;
      cond_hi: return c && !z;
      cond_ls: return !c || z;
      cond_ge: return n == v;
      cond_lt: return n != v;
      cond_gt: return !z && (n == v);
      cond_le: return z || (n != v);
      default: return 1'b1;
    endcase
  endfunction

  task automatic run_model();
    instr_t      w;
    int          pc;
    int          steps;
    logic        n, z, c, v;
    logic [31:0] a, b, r;
    logic [32:0] wide;
    logic [3:0]  addr;
    {n, z, c, v} = 4'b0000;
    foreach (model_regs[k]) model_regs[k] = '0;
    foreach (model_mem[k]) model_mem[k] = '0;
    pc = 0;
    steps = 0;
    while (pc != 15 && steps < 64) begin
      w = prog[pc];
      steps++;
      pc++;
      if (w.dp.cls == type_data_proc) begin
        a = model_regs[w.dp.rn];
        b = w.dp.imm ? {24'd0, w.dp.operand2[7:0]} : model_regs[w.dp.operand2[3:0]];
        wide = {1'b0, a} + {1'b0, b};
        case (w.dp.opcode)
          opcode_and: r = a & b;
          opcode_eor: r = a ^ b;
          opcode_orr: r = a | b;
          opcode_bic: r = a & ~b;
          opcode_mov: r = b;
          opcode_mvn: r = ~b;
          opcode_add: r = wide[31:0];
          default:    r = a - b;
        endcase
        if (w.dp.s || w.dp.opcode == opcode_cmp) begin
          n = r[31];
          z = r == 0;
          // c and v only move on arithmetic
          if (w.dp.opcode == opcode_add) begin
            c = wide[32];
            v = (a[31] == b[31]) && (r[31] != a[31]);
          end else if (w.dp.opcode == opcode_sub || w.dp.opcode == opcode_cmp) begin
            c = a >= b;
            v = (a[31] != b[31]) && (r[31] != a[31]);
          end
        end
        if (w.dp.opcode != opcode_cmp) begin
          model_regs[w.dp.rd] = r;
          exp_reg.push_back(w.dp.rd);
          exp_val.push_back(r);
        end
      end else if (w.mem.cls == type_ldr_str) begin
        r = model_regs[w.mem.rn] + {20'd0, w.mem.imm12};
        addr = 4'((r >> 2) % data_words);
        if (w.mem.load) begin
          model_regs[w.mem.rd] = model_mem[addr];
          exp_reg.push_back(w.mem.rd);
          exp_val.push_back(model_mem[addr]);
        end else begin
          model_mem[addr] = model_regs[w.mem.rd];
          exp_saddr.push_back(addr);
          exp_sdata.push_back(model_regs[w.mem.rd]);
        end
      end else if (cond_holds(w.br.cond, n, z, c, v)) begin
        // pc + 8 + 4 * offset, counted in words from the branch itself
        pc = pc + 1 + int'(signed'(w.br.offset));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // result checkers, sampled on the falling edge

  task automatic check_retire();
    logic [3:0]  r;
    logic [31:0] d;
    assert (exp_reg.size() > 0) else begin
      other_errors++;
      $display("unexpected register write to r%0d", retire_reg);
    end
    if (exp_reg.size() > 0) begin
      r = exp_reg.pop_front();
      d = exp_val.pop_front();
      assert (retire_reg == r) else begin
        retire_errors++;
        $display("MISMATCH retire_reg got %h expected %h", retire_reg, r);
      end
      assert (retire_data == d) else begin
        retire_errors++;
        $display("MISMATCH retire_data got %h expected %h", retire_data, d);
      end
    end
  endtask

  task automatic check_store();
    logic [3:0]  a;
    logic [31:0] d;
    assert (exp_saddr.size() > 0) else begin
      other_errors++;
      $display("unexpected store to word %0d", store_addr);
    end
    if (exp_saddr.size() > 0) begin
      a = exp_saddr.pop_front();
      d = exp_sdata.pop_front();
      assert (store_addr == a) else begin
        store_errors++;
        $display("MISMATCH store_addr got %h expected %h", store_addr, a);
      end
      assert (store_data == d) else begin
        store_errors++;
        $display("MISMATCH store_data got %h expected %h", store_data, d);
      end
    end
  endtask

  always @(negedge clk) begin
    if (!nreset) begin
      assert (!retire_valid && !store_valid) else begin
        other_errors++;
        $display("strobe high while reset is asserted");
      end
    end else begin
      if (retire_valid) begin
        check_retire();
      end
      if (store_valid) begin
        check_store();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // one program: load in reset, release, drain, then idle

  task automatic run_program(input int p);
    int cycles;
    gen_program();
    for (int k = 0; k < code_words; k++) begin
      @(posedge clk);
      nreset     <= 1'b0;
      imem_we    <= 1'b1;
      imem_addr  <= 4'(k);
      imem_wdata <= prog[k];
    end
    @(posedge clk);
    imem_we <= 1'b0;
    run_model();
    repeat (2) @(posedge clk);
    nreset <= 1'b1;
    cycles = 0;
    while ((exp_reg.size() > 0 || exp_saddr.size() > 0) && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    assert (exp_reg.size() == 0 && exp_saddr.size() == 0) else begin
      other_errors++;
      timed_out = 1'b1;
      $display("program %0d timed out with %0d register writes and %0d stores missing",
               p, exp_reg.size(), exp_saddr.size());
    end
    // the self-branch must stay silent
    if (!timed_out) begin
      repeat (50) @(posedge clk);
    end
  endtask

  initial begin
    nreset        = 1'b0;
    imem_we       = 1'b0;
    imem_addr     = '0;
    imem_wdata    = '0;
    lfsr_state    = 32'h72dea744;
    retire_errors = 0;
    store_errors  = 0;
    other_errors  = 0;
    timed_out     = 1'b0;
    for (int p = 0; p < 3 && !timed_out; p++) begin
      run_program(p);
    end
    $display("errors: retire %0d, store %0d, other %0d, assertions %0d",
             retire_errors, store_errors, other_errors, UUT.u_assertions.failures);
    if (retire_errors + store_errors + other_errors + UUT.u_assertions.failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* sim/cpu_assertions.sv */
`timescale 1ns/10ps

module cpu_assertions import cpu_pkg::*; (
  input logic                       clk,
  input logic                       nreset,
  input logic                       stall,
  input logic                       retire_valid,
  input logic [reg_index_width-1:0] retire_reg,
  input logic                       store_valid
);

  // failure count, read by the testbench at the end of the run
  int failures = 0;

  // r15 is the pc, never a write-back target
  no_r15_retire: assert property (@(posedge clk) disable iff (!nreset)
    retire_valid |-> retire_reg != reg_r15)
    else begin
      $error("register write to r15 retired");
      failures++;
    end

  // the bubble behind a load clears the hazard, so a hold lasts one cycle
  single_cycle_stall: assert property (@(posedge clk) disable iff (!nreset)
    stall |=> !stall)
    else begin
      $error("load-use stall held for two cycles");
      failures++;
    end

  // both strobes stay quiet in reset
  quiet_in_reset: assert property (@(posedge clk)
    !nreset |-> !$rose(retire_valid) && !$rose(store_valid))
    else begin
      $error("strobe rose while reset was asserted");
      failures++;
    end

endmodule

bind cpu_top cpu_assertions u_assertions (
  .clk          (clk),
  .nreset       (nreset),
  .stall        (stall),
  .retire_valid (retire_valid),
  .retire_reg   (retire_reg),
  .store_valid  (store_valid)
);

/* design/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; #(
  parameter int CODE_WORDS = 16,
  parameter int DATA_WORDS = 16
) (
  input  logic                          clk,
  input  logic                          nreset,
  input  logic                          imem_we,
  input  logic [$clog2(CODE_WORDS)-1:0] imem_addr,
  input  logic [word_width-1:0]         imem_wdata,
  output logic                          retire_valid,
  output logic [reg_index_width-1:0]    retire_reg,
  output logic [word_width-1:0]         retire_data,
  output logic                          store_valid,
  output logic [$clog2(DATA_WORDS)-1:0] store_addr,
  output logic [word_width-1:0]         store_data
);

  // redirect and hold
  logic                  branch_taken, stall;
  logic [word_width-1:0] branch_target;

  // fetch to decode
  logic                  fd_valid;
  instr_t                fd_instr;
  logic [word_width-1:0] fd_pc;

  // register file read ports
  logic [reg_index_width-1:0] rf_raddr_a, rf_raddr_b, rf_raddr_c;
  logic [word_width-1:0]      rf_rdata_a, rf_rdata_b, rf_rdata_c;

  // decode to execute
  logic                       de_valid, rf_we, mem_we, mem_re;
  instr_t                     de_instr;
  logic [word_width-1:0]      de_pc, rn_data, rm_data, rd_data;
  logic [reg_index_width-1:0] rn_idx, rm_idx, rd_idx, dest_reg;

  // execute to memory
  logic                       em_valid, em_rf_we, em_mem_we, em_mem_re;
  logic [word_width-1:0]      em_result, em_store_data;
  logic [reg_index_width-1:0] em_dest_reg;

  // memory to write-back
  logic                       mw_valid, mw_rf_we, wb_we;
  logic [reg_index_width-1:0] mw_dest_reg;
  logic [word_width-1:0]      mw_data;

  ////////////////////////////////////////////////////////////////////////////
  // pipeline stages

  fetch_stage #(.CODE_WORDS(CODE_WORDS)) u_fetch (.*);

  decode_stage u_decode (.*);

  execute_stage u_execute (.*);

  memory_stage #(.DATA_WORDS(DATA_WORDS)) u_memory (.*);

  // write-back has no register of its own, the mw register feeds the file
  register_file u_regs (
    .clk     (clk),
    .nreset  (nreset),
    .raddr_a (rf_raddr_a),
    .raddr_b (rf_raddr_b),
    .raddr_c (rf_raddr_c),
    .rdata_a (rf_rdata_a),
    .rdata_b (rf_rdata_b),
    .rdata_c (rf_rdata_c),
    .we      (wb_we),
    .waddr   (mw_dest_reg),
    .wdata   (mw_data)
  );

  // one retire pulse per committed register write
  assign wb_we        = mw_valid & mw_rf_we;
  assign retire_valid = wb_we;
  assign retire_reg   = mw_dest_reg;
  assign retire_data  = mw_data;

endmodule

/* design/memory_stage.sv */
`timescale 1ns/10ps

module memory_stage import cpu_pkg::*; #(
  parameter int DATA_WORDS = 16,
  localparam int data_addr_width = $clog2(DATA_WORDS)
) (
  input  logic                       clk,
  input  logic                       nreset,
  input  logic                       em_valid,
  input  logic [word_width-1:0]      em_result,
  input  logic [word_width-1:0]      em_store_data,
  input  logic [reg_index_width-1:0] em_dest_reg,
  input  logic                       em_rf_we,
  input  logic                       em_mem_we,
  input  logic                       em_mem_re,
  output logic                       store_valid,
  output logic [data_addr_width-1:0] store_addr,
  output logic [word_width-1:0]      store_data,
  output logic                       mw_valid,
  output logic [reg_index_width-1:0] mw_dest_reg,
  output logic                       mw_rf_we,
  output logic [word_width-1:0]      mw_data
);

  logic [word_width-1:0]      data_mem [0:DATA_WORDS-1];
  logic [data_addr_width-1:0] addr;

  // word address, wraps modulo DATA_WORDS
  assign addr = em_result[2 +: data_addr_width];

  // store strobe is live during the em cycle
  assign store_valid = em_valid && em_mem_we;
  assign store_addr  = addr;
  assign store_data  = em_store_data;

  always_ff @(posedge clk) begin
    if (!nreset) begin
      for (int i = 0; i < DATA_WORDS; i++) begin
        data_mem[i] <= '0;
      end
      mw_valid <= 1'b0;
      mw_rf_we <= 1'b0;
    end else begin
      if (store_valid) begin
        data_mem[addr] <= em_store_data;
      end
      mw_valid <= em_valid;
      mw_rf_we <= em_rf_we;
    end
  end

  // loaded word or alu result on to write-back
  always_ff @(posedge clk) begin
    mw_dest_reg <= em_dest_reg;
    mw_data     <= em_mem_re ? data_mem[addr] : em_result;
  end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       nreset,
  input  logic                       de_valid,
  input  instr_t                     de_instr,
  input  logic [word_width-1:0]      de_pc,
  input  logic [word_width-1:0]      rn_data,
  input  logic [word_width-1:0]      rm_data,
  input  logic [word_width-1:0]      rd_data,
  input  logic [reg_index_width-1:0] rn_idx,
  input  logic [reg_index_width-1:0] rm_idx,
  input  logic [reg_index_width-1:0] rd_idx,
  input  logic [reg_index_width-1:0] dest_reg,
  input  logic                       rf_we,
  input  logic                       mem_we,
  input  logic                       mem_re,
  input  logic [word_width-1:0]      mw_data,
  input  logic [reg_index_width-1:0] mw_dest_reg,
  input  logic                       mw_rf_we,
  input  logic                       mw_valid,
  output logic                       branch_taken,
  output logic [word_width-1:0]      branch_target,
  output logic                       em_valid,
  output logic [word_width-1:0]      em_result,
  output logic [word_width-1:0]      em_store_data,
  output logic [reg_index_width-1:0] em_dest_reg,
  output logic                       em_rf_we,
  output logic                       em_mem_we,
  output logic                       em_mem_re
);

  logic [word_width-1:0] op_a, op_b, op_d, operand2, addend, result;
  logic [word_width:0]   sum;
  logic flag_n, flag_z, flag_c, flag_v;
  logic em_fwd, mw_fwd, subtract, arith, overflow, set_flags, cond_ok;

  ////////////////////////////////////////////////////////////////////////////
  // forwarding, em is younger so it wins; a load in em has no data yet

  assign em_fwd = em_valid && em_rf_we && !em_mem_re;
  assign mw_fwd = mw_valid && mw_rf_we;
  assign op_a = (em_fwd && em_dest_reg == rn_idx) ? em_result :
                (mw_fwd && mw_dest_reg == rn_idx) ? mw_data : rn_data;
  assign op_b = (em_fwd && em_dest_reg == rm_idx) ? em_result :
                (mw_fwd && mw_dest_reg == rm_idx) ? mw_data : rm_data;
  assign op_d = (em_fwd && em_dest_reg == rd_idx) ? em_result :
                (mw_fwd && mw_dest_reg == rd_idx) ? mw_data : rd_data;

  // unrotated imm8 or rm
  assign operand2 = de_instr.dp.imm ?
                    {{(word_width-8){1'b0}}, de_instr.dp.operand2[7:0]} : op_b;

  ////////////////////////////////////////////////////////////////////////////
  // alu, one adder shared by add, sub and cmp

  assign subtract = de_instr.dp.opcode == opcode_sub || de_instr.dp.opcode == opcode_cmp;
  assign arith    = subtract || de_instr.dp.opcode == opcode_add;
  assign addend   = subtract ? ~operand2 : operand2;
  assign sum      = {1'b0, op_a} + {1'b0, addend} + (word_width+1)'(subtract);
  // signed overflow when both inputs agree in sign and the sum does not
  assign overflow = (op_a[word_width-1] == addend[word_width-1]) &&
                    (sum[word_width-1] != op_a[word_width-1]);

  always_comb begin
    case (de_instr.dp.opcode)
      opcode_and: result = op_a & operand2;
      opcode_eor: result = op_a ^ operand2;
      opcode_orr: result = op_a | operand2;
      opcode_mov: result = operand2;
      opcode_bic: result = op_a & ~operand2;
      opcode_mvn: result = ~operand2;
      default:    result = sum[word_width-1:0];
    endcase
    // load/store address, base plus offset
    if (de_instr.mem.cls == type_ldr_str) begin
      result = op_a + {{(word_width-12){1'b0}}, de_instr.mem.imm12};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // condition check and redirect

  always_comb begin
    case (de_instr.br.cond)
      cond_eq: cond_ok = flag_z;
      cond_ne: cond_ok = !flag_z;
      cond_cs: cond_ok = flag_c;
      cond_cc: cond_ok = !flag_c;
      cond_mi: cond_ok = flag_n;
      cond_pl: cond_ok = !flag_n;
      cond_vs: cond_ok = flag_v;
      cond_vc: cond_ok = !flag_v;
      cond_hi: cond_ok = flag_c && !flag_z;
      cond_ls: cond_ok = !flag_c || flag_z;
      cond_ge: cond_ok = flag_n == flag_v;
      cond_lt: cond_ok = flag_n != flag_v;
      cond_gt: cond_ok = !flag_z && flag_n == flag_v;
      cond_le: cond_ok = flag_z || flag_n != flag_v;
      default: cond_ok = 1'b1;
    endcase
  end

  assign branch_taken  = de_valid && de_instr.br.cls == type_branch && cond_ok;
  assign branch_target = de_pc + word_width'(8) +
                         {{6{de_instr.br.offset[23]}}, de_instr.br.offset, 2'b00};

  assign set_flags = de_valid && de_instr.dp.cls == type_data_proc &&
                     (de_instr.dp.s || de_instr.dp.opcode == opcode_cmp);

  // logical ops leave c and v alone
  always_ff @(posedge clk) begin
    if (!nreset) begin
      {flag_n, flag_z, flag_c, flag_v} <= 4'b0000;
      em_valid  <= 1'b0;
      em_rf_we  <= 1'b0;
      em_mem_we <= 1'b0;
      em_mem_re <= 1'b0;
    end else begin
      if (set_flags) begin
        flag_n <= result[word_width-1];
        flag_z <= result == '0;
        flag_c <= arith ? sum[word_width] : flag_c;
        flag_v <= arith ? overflow : flag_v;
      end
      em_valid  <= de_valid;
      em_rf_we  <= rf_we;
      em_mem_we <= mem_we;
      em_mem_re <= mem_re;
    end
  end

  always_ff @(posedge clk) begin
    em_result     <= result;
    em_store_data <= op_d;
    em_dest_reg   <= dest_reg;
  end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       nreset,
  input  logic                       fd_valid,
  input  instr_t                     fd_instr,
  input  logic [word_width-1:0]      fd_pc,
  input  logic                       branch_taken,
  input  logic [word_width-1:0]      rf_rdata_a,
  input  logic [word_width-1:0]      rf_rdata_b,
  input  logic [word_width-1:0]      rf_rdata_c,
  output logic [reg_index_width-1:0] rf_raddr_a,
  output logic [reg_index_width-1:0] rf_raddr_b,
  output logic [reg_index_width-1:0] rf_raddr_c,
  output logic                       stall,
  output logic                       de_valid,
  output instr_t                     de_instr,
  output logic [word_width-1:0]      de_pc,
  output logic [word_width-1:0]      rn_data,
  output logic [word_width-1:0]      rm_data,
  output logic [word_width-1:0]      rd_data,
  output logic [reg_index_width-1:0] rn_idx,
  output logic [reg_index_width-1:0] rm_idx,
  output logic [reg_index_width-1:0] rd_idx,
  output logic [reg_index_width-1:0] dest_reg,
  output logic                       rf_we,
  output logic                       mem_we,
  output logic                       mem_re
);

  logic is_dp, is_mem, is_load;
  logic uses_rn, uses_rm, uses_rd;
  logic dec_rf_we, dec_mem_we, dec_mem_re;

  // class split
  assign is_dp   = fd_instr.dp.cls == type_data_proc;
  assign is_mem  = fd_instr.mem.cls == type_ldr_str;
  assign is_load = is_mem && fd_instr.mem.load;

  // rn base or first operand, rm second operand, rd store data
  assign rf_raddr_a = fd_instr.dp.rn;
  assign rf_raddr_b = fd_instr.dp.operand2[3:0];
  assign rf_raddr_c = fd_instr.mem.rd;

  // which sources the fd instruction really reads
  assign uses_rn = (is_dp && fd_instr.dp.opcode != opcode_mov &&
                    fd_instr.dp.opcode != opcode_mvn) || is_mem;
  assign uses_rm = is_dp && !fd_instr.dp.imm;
  assign uses_rd = is_mem && !fd_instr.mem.load;

  // cmp only sets flags, r15 is never a destination
  assign dec_rf_we  = ((is_dp && fd_instr.dp.opcode != opcode_cmp) || is_load) &&
                      fd_instr.dp.rd != reg_r15;
  assign dec_mem_we = is_mem && !fd_instr.mem.load;
  assign dec_mem_re = is_load;

  // load in execute whose result the next instruction needs
  assign stall = fd_valid && de_valid && mem_re &&
                 ((uses_rn && rf_raddr_a == dest_reg) ||
                  (uses_rm && rf_raddr_b == dest_reg) ||
                  (uses_rd && rf_raddr_c == dest_reg));

  // a stall or a flush sends a bubble down
  always_ff @(posedge clk) begin
    if (!nreset) begin
      de_valid <= 1'b0;
      rf_we    <= 1'b0;
      mem_we   <= 1'b0;
      mem_re   <= 1'b0;
    end else begin
      de_valid <= fd_valid && !stall && !branch_taken;
      rf_we    <= dec_rf_we;
      mem_we   <= dec_mem_we;
      mem_re   <= dec_mem_re;
    end
  end

  always_ff @(posedge clk) begin
    de_instr <= fd_instr;
    de_pc    <= fd_pc;
    rn_data  <= rf_rdata_a;
    rm_data  <= rf_rdata_b;
    rd_data  <= rf_rdata_c;
    rn_idx   <= rf_raddr_a;
    rm_idx   <= rf_raddr_b;
    rd_idx   <= rf_raddr_c;
    dest_reg <= fd_instr.dp.rd;
  end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage import cpu_pkg::*; #(
  parameter int CODE_WORDS = 16,
  localparam int code_addr_width = $clog2(CODE_WORDS)
) (
  input  logic                       clk,
  input  logic                       nreset,
  input  logic                       imem_we,
  input  logic [code_addr_width-1:0] imem_addr,
  input  logic [word_width-1:0]      imem_wdata,
  input  logic                       stall,
  input  logic                       branch_taken,
  input  logic [word_width-1:0]      branch_target,
  output logic                       fd_valid,
  output instr_t                     fd_instr,
  output logic [word_width-1:0]      fd_pc
);

  logic [word_width-1:0] code_mem [0:CODE_WORDS-1];
  logic [word_width-1:0] pc;

  // program load port, only open while the core is held in reset
  always_ff @(posedge clk) begin
    if (!nreset && imem_we) begin
      code_mem[imem_addr] <= imem_wdata;
    end
  end

  // redirect wins over stall
  always_ff @(posedge clk) begin
    if (!nreset) begin
      pc       <= '0;
      fd_valid <= 1'b0;
    end else if (branch_taken) begin
      pc       <= branch_target;
      fd_valid <= 1'b0;
    end else if (!stall) begin
      pc       <= pc + word_width'(4);
      fd_valid <= 1'b1;
    end
  end

  // word index is pc bits above the byte offset
  always_ff @(posedge clk) begin
    if (!stall) begin
      fd_instr <= code_mem[pc[2 +: code_addr_width]];
      fd_pc    <= pc;
    end
  end

endmodule

/* design/register_file.sv */
`timescale 1ns/10ps

module register_file import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       nreset,
  input  logic [reg_index_width-1:0] raddr_a,
  input  logic [reg_index_width-1:0] raddr_b,
  input  logic [reg_index_width-1:0] raddr_c,
  output logic [word_width-1:0]      rdata_a,
  output logic [word_width-1:0]      rdata_b,
  output logic [word_width-1:0]      rdata_c,
  input  logic                       we,
  input  logic [reg_index_width-1:0] waddr,
  input  logic [word_width-1:0]      wdata
);

  // r0 to r14
  logic [word_width-1:0] regs [0:14];

  always_ff @(posedge clk) begin
    if (!nreset) begin
      for (int i = 0; i < 15; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != reg_r15) begin
      regs[waddr] <= wdata;
    end
  end

  // r15 reads zero, a same-cycle write shows through to decode
  assign rdata_a = (raddr_a == reg_r15) ? '0 :
                   (we && waddr == raddr_a) ? wdata : regs[raddr_a];
  assign rdata_b = (raddr_b == reg_r15) ? '0 :
                   (we && waddr == raddr_b) ? wdata : regs[raddr_b];
  assign rdata_c = (raddr_c == reg_r15) ? '0 :
                   (we && waddr == raddr_c) ? wdata : regs[raddr_c];

endmodule

/* design/cpu_pkg.sv */
package cpu_pkg;

  // datapath and register index widths
  localparam int word_width = 32;
  localparam int reg_index_width = 4;

  // r15 is the pc and is never read or written as a general register
  localparam logic [reg_index_width-1:0] reg_r15 = '1;

  // condition field, bits 31:28
  localparam logic [3:0] cond_eq = 4'b0000;
  localparam logic [3:0] cond_ne = 4'b0001;
  localparam logic [3:0] cond_cs = 4'b0010;
  localparam logic [3:0] cond_cc = 4'b0011;
  localparam logic [3:0] cond_mi = 4'b0100;
  localparam logic [3:0] cond_pl = 4'b0101;
  localparam logic [3:0] cond_vs = 4'b0110;
  localparam logic [3:0] cond_vc = 4'b0111;
  localparam logic [3:0] cond_hi = 4'b1000;
  localparam logic [3:0] cond_ls = 4'b1001;
  localparam logic [3:0] cond_ge = 4'b1010;
  localparam logic [3:0] cond_lt = 4'b1011;
  localparam logic [3:0] cond_gt = 4'b1100;
  localparam logic [3:0] cond_le = 4'b1101;
  localparam logic [3:0] cond_al = 4'b1110;

  // data processing opcodes, bits 24:21
  localparam logic [3:0] opcode_and = 4'b0000;
  localparam logic [3:0] opcode_eor = 4'b0001;
  localparam logic [3:0] opcode_sub = 4'b0010;
  localparam logic [3:0] opcode_add = 4'b0100;
  localparam logic [3:0] opcode_cmp = 4'b1010;
  localparam logic [3:0] opcode_orr = 4'b1100;
  localparam logic [3:0] opcode_mov = 4'b1101;
  localparam logic [3:0] opcode_bic = 4'b1110;
  localparam logic [3:0] opcode_mvn = 4'b1111;

  // instruction class, bits 27:26
  localparam logic [1:0] type_data_proc = 2'b00;
  localparam logic [1:0] type_ldr_str   = 2'b01;
  localparam logic [1:0] type_branch    = 2'b10;

  // one instruction word, three layouts selected by the class field
  typedef union packed {
    struct packed {
      logic [3:0]                 cond;
      logic [1:0]                 cls;
      logic                       imm;
      logic [3:0]                 opcode;
      logic                       s;
      logic [reg_index_width-1:0] rn;
      logic [reg_index_width-1:0] rd;
      // imm8 in 7:0 or rm in 3:0
      logic [11:0]                operand2;
    } dp;
    struct packed {
      logic [3:0]                 cond;
      logic [1:0]                 cls;
      logic                       imm_off;
      logic                       pre;
      logic                       up;
      logic                       byte_sel;
      logic                       wback;
      logic                       load;
      logic [reg_index_width-1:0] rn;
      logic [reg_index_width-1:0] rd;
      logic [11:0]                imm12;
    } mem;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  cls;
      // bit 25, always set in a branch word
      logic        op;
      logic        link;
      // signed word offset
      logic [23:0] offset;
    } br;
  } instr_t;

endpackage
